/* branch_predict_top.f */
+incdir+design
design/pred_pkg.sv
design/btb_pkg.sv
design/resolve_if.sv
design/branch_target_buffer.sv
design/gshare_predictor.sv
design/pending_branch_queue.sv
design/branch_predict_top.sv
dv/branch_predict_sva.sv
dv/branch_predict_tb.sv

/* Makefile */
TOP := branch_predict_tb
OUT := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal \
		-f branch_predict_top.f --top-module $(TOP) -Mdir $(OUT) -o sim

# The log decides the verdict, since the simulator exits cleanly either way.
run: build
	./$(OUT)/sim | tee sim.log
	grep -q "^SIMULATION PASSED$$" sim.log

lint:
	verilator --lint-only -Wall --timing --assert \
		-f branch_predict_top.f --top-module $(TOP)

clean:
	rm -rf $(OUT) sim.log

/* dv/branch_predict_tb.sv */
`timescale 1ns/1ns

`include "bp_settings.svh"

module branch_predict_tb;

    localparam int unsigned PC_W  = `BP_PC_W;
    localparam int unsigned IDX_W = $clog2(`BP_TABLE_DEPTH);
    localparam int unsigned SET_W = $clog2(`BP_BTB_ENTRIES);
    localparam int unsigned OFS   = `BP_WORD_OFFSET;
    // The whole sequence needs well under 500 cycles, so the limit only trips on a hang.
    localparam int unsigned LIMIT = 4000;

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    lookup_i;
    logic [PC_W-1:0]         lookup_pc_i;
    logic                    install_i;
    logic [PC_W-1:0]         install_pc_i;
    logic [PC_W-1:0]         install_target_i;
    logic                    resolve_i;
    logic                    resolve_taken_i;
    logic [PC_W-1:0]         resolve_target_i;
    logic                    predict_valid_o;
    logic                    predict_taken_o;
    logic [PC_W-1:0]         predict_target_o;
    logic                    mispredict_o;

    // Reference model state, updated once per rising edge.
    logic                    m_btb_valid  [`BP_BTB_ENTRIES];
    logic [PC_W-1:0]         m_btb_tag    [`BP_BTB_ENTRIES];
    logic [PC_W-1:0]         m_btb_target [`BP_BTB_ENTRIES];
    logic [1:0]              m_ctr        [`BP_TABLE_DEPTH];
    logic [`BP_HIST_LEN-1:0] m_hist;
    logic [IDX_W-1:0]        m_pend_idx    [$];
    logic                    m_pend_taken  [$];
    logic [PC_W-1:0]         m_pend_target [$];
    logic                    m_hit;
    logic [PC_W-1:0]         m_hit_target;
    logic [PC_W-1:0]         m_hit_pc;

    // Outputs the model expects in the current cycle.
    logic                    exp_valid;
    logic                    exp_taken;
    logic [IDX_W-1:0]        exp_idx;
    logic [PC_W-1:0]         exp_target;
    logic                    exp_mispredict;

    logic [PC_W-1:0]         br_pc  [4];
    logic [PC_W-1:0]         br_tgt [4];
    int                      error_count = 0;
    int                      check_count = 0;
    int                      test_count  = 0;
    int                      cycle_count = 0;
    integer                  seed = 61833;

    branch_predict_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles.", LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [PC_W-1:0] got,
                                 input logic [PC_W-1:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Applies the effect of one clock edge to the model.
    // The inputs still hold the values of the cycle that is ending.
    function automatic void model_edge();
        logic [IDX_W-1:0] h_idx;
        logic             h_taken;
        logic [PC_W-1:0]  h_target;
        logic [SET_W-1:0] set;
        exp_mispredict = 1'b0;
        if (resolve_i && m_pend_idx.size() > 0) begin
            h_idx    = m_pend_idx.pop_front();
            h_taken  = m_pend_taken.pop_front();
            h_target = m_pend_target.pop_front();
            // A taken branch must also have gone to the predicted target.
            exp_mispredict = (resolve_taken_i != h_taken) ||
                             (resolve_taken_i && (resolve_target_i != h_target));
            if (resolve_taken_i && m_ctr[h_idx] != 2'd3) begin
                m_ctr[h_idx] = m_ctr[h_idx] + 2'd1;
            end else if (!resolve_taken_i && m_ctr[h_idx] != 2'd0) begin
                m_ctr[h_idx] = m_ctr[h_idx] - 2'd1;
            end
            m_hist = {m_hist[`BP_HIST_LEN-2:0], resolve_taken_i};
        end
        // The prediction shown in the ending cycle joins the back of the list.
        if (exp_valid) begin
            m_pend_idx.push_back(exp_idx);
            m_pend_taken.push_back(exp_taken);
            m_pend_target.push_back(exp_target);
        end
        set          = lookup_pc_i[SET_W+OFS-1:OFS];
        m_hit        = lookup_i && m_btb_valid[set] &&
                       (m_btb_tag[set] == lookup_pc_i >> (SET_W+OFS));
        m_hit_target = m_btb_target[set];
        m_hit_pc     = lookup_pc_i;
        if (install_i) begin
            set               = install_pc_i[SET_W+OFS-1:OFS];
            m_btb_valid[set]  = 1'b1;
            m_btb_tag[set]    = install_pc_i >> (SET_W+OFS);
            m_btb_target[set] = install_target_i;
        end
        exp_valid  = m_hit && (m_pend_idx.size() < `BP_QUEUE_DEPTH);
        exp_idx    = m_hit_pc[IDX_W+OFS-1:OFS] ^ IDX_W'(m_hist);
        exp_taken  = m_ctr[exp_idx][1];
        exp_target = m_hit_target;
    endfunction

    // Runs one clock cycle with the model step and new inputs at the rising edge
    // and the checks at the falling edge.
    task automatic run_cycle(input logic lk, input logic [PC_W-1:0] lk_pc,
                             input logic ins, input logic [PC_W-1:0] ins_pc,
                             input logic [PC_W-1:0] ins_tgt, input logic rs,
                             input logic rs_taken, input logic [PC_W-1:0] rs_tgt);
        @(posedge clk_i);
        model_edge();
        lookup_i         <= lk;
        lookup_pc_i      <= lk_pc;
        install_i        <= ins;
        install_pc_i     <= ins_pc;
        install_target_i <= ins_tgt;
        resolve_i        <= rs;
        resolve_taken_i  <= rs_taken;
        resolve_target_i <= rs_tgt;
        @(negedge clk_i);
        compare_value("predict_valid_o", predict_valid_o, exp_valid);
        if (exp_valid) begin
            compare_value("predict_taken_o", predict_taken_o, exp_taken);
            compare_value("predict_target_o", predict_target_o, exp_target);
        end
        compare_value("mispredict_o", mispredict_o, exp_mispredict);
    endtask

    task automatic idle();
        run_cycle(1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic apply_reset();
        rst_n_i <= 1'b0;
        repeat (10) @(posedge clk_i);
        for (int i = 0; i < `BP_BTB_ENTRIES; i++) m_btb_valid[i] = 1'b0;
        for (int i = 0; i < `BP_TABLE_DEPTH; i++) m_ctr[i] = 2'b01;
        m_hist = '0;
        m_pend_idx.delete();
        m_pend_taken.delete();
        m_pend_target.delete();
        m_hit          = 1'b0;
        exp_valid      = 1'b0;
        exp_mispredict = 1'b0;
        rst_n_i <= 1'b1;
    endtask

    // Resolves everything still pending with the predicted outcome.
    task automatic drain_pending();
        logic            taken_snap  [$];
        logic [PC_W-1:0] target_snap [$];
        idle();
        idle();
        taken_snap  = m_pend_taken;
        target_snap = m_pend_target;
        foreach (taken_snap[i]) begin
            run_cycle(1'b0, '0, 1'b0, '0, '0, 1'b1, taken_snap[i], target_snap[i]);
        end
        idle();
    endtask

    // Each round looks up a random branch and resolves the previous one while
    // the new prediction is on the outputs.
    task automatic train_branches(input int rounds, input int taken_pct, input int change_pct);
        int              k;
        logic            taken;
        logic [PC_W-1:0] target;
        logic            have_prev;
        logic            prev_taken;
        logic [PC_W-1:0] prev_target;
        have_prev   = 1'b0;
        prev_taken  = 1'b0;
        prev_target = '0;
        for (int r = 0; r < rounds; r++) begin
            k      = $unsigned($random(seed)) % 4;
            taken  = ($unsigned($random(seed)) % 100) < taken_pct;
            target = br_tgt[k];
            if (($unsigned($random(seed)) % 100) < change_pct) target = target + 32'h40;
            run_cycle(1'b1, br_pc[k], 1'b0, '0, '0, 1'b0, 1'b0, '0);
            run_cycle(1'b0, '0, 1'b0, '0, '0, have_prev, prev_taken, prev_target);
            have_prev   = 1'b1;
            prev_taken  = taken;
            prev_target = target;
        end
        drain_pending();
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("test %0d %s: %s, %0d errors", test_count, name,
                 (error_count == errors_before) ? "ok" : "mismatches",
                 error_count - errors_before);
    endtask

    initial begin
        int              errs;
        logic [PC_W-1:0] pc;
        logic [PC_W-1:0] tgt;
        rst_n_i          = 1'b0;
        lookup_i         = 1'b0;
        lookup_pc_i      = '0;
        install_i        = 1'b0;
        install_pc_i     = '0;
        install_target_i = '0;
        resolve_i        = 1'b0;
        resolve_taken_i  = 1'b0;
        resolve_target_i = '0;
        apply_reset();

        // The BTB is empty after reset, so nothing may predict.
        errs = error_count;
        for (int i = 0; i < 8; i++) begin
            pc = $random(seed);
            run_cycle(1'b1, {pc[PC_W-1:OFS], OFS'(0)}, 1'b0, '0, '0, 1'b0, 1'b0, '0);
        end
        idle();
        report_test("empty btb", errs);

        errs = error_count;
        pc  = $random(seed);
        tgt = $random(seed);
        pc[OFS-1:0]  = '0;
        tgt[OFS-1:0] = '0;
        run_cycle(1'b0, '0, 1'b1, pc, tgt, 1'b0, 1'b0, '0);
        run_cycle(1'b1, pc, 1'b0, '0, '0, 1'b0, 1'b0, '0);
        idle();
        drain_pending();
        report_test("install then lookup", errs);

        // Four branches in four different sets.
        errs = error_count;
        for (int k = 0; k < 4; k++) begin
            pc  = $random(seed);
            tgt = $random(seed);
            br_pc[k]  = {pc[PC_W-1:SET_W+OFS], SET_W'(k), OFS'(0)};
            br_tgt[k] = {tgt[PC_W-1:OFS], OFS'(0)};
            run_cycle(1'b0, '0, 1'b1, br_pc[k], br_tgt[k], 1'b0, 1'b0, '0);
        end
        train_branches(40, 50, 0);
        report_test("counter training", errs);

        // One branch moves to a new target and later resolves often disagree on the target.
        errs = error_count;
        tgt = $random(seed);
        br_tgt[1] = {tgt[PC_W-1:OFS], OFS'(0)};
        run_cycle(1'b0, '0, 1'b1, br_pc[1], br_tgt[1], 1'b0, 1'b0, '0);
        train_branches(30, 75, 35);
        report_test("mispredict", errs);

        // Five lookups in a row; the fifth finds the queue full.
        errs = error_count;
        for (int i = 0; i < 5; i++) begin
            run_cycle(1'b1, br_pc[0], 1'b0, '0, '0, 1'b0, 1'b0, '0);
        end
        idle();
        run_cycle(1'b0, '0, 1'b0, '0, '0, 1'b1, m_pend_taken[0], m_pend_target[0]);
        run_cycle(1'b1, br_pc[0], 1'b0, '0, '0, 1'b0, 1'b0, '0);
        idle();
        drain_pending();
        report_test("queue full", errs);

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* dv/branch_predict_sva.sv */
`timescale 1ns/1ns

`include "bp_settings.svh"

// Checks shared by the pending queue and the predictor.
// Each instance ties off the inputs whose checks belong to the other block.
module branch_predict_sva (
    input logic                               clk_i,
    input logic                               rst_n_i,
    input logic [$clog2(`BP_QUEUE_DEPTH):0]   count_i,
    input logic                               push_i,
    input logic                               full_i,
    input logic                               resolve_i,
    input logic                               not_empty_i,
    input logic                               mispredict_i,
    input logic                               predict_valid_i
);

    localparam int unsigned CNT_W = $clog2(`BP_QUEUE_DEPTH) + 1;

    // The occupancy never goes past the queue depth.
    occupancy_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_i <= CNT_W'(`BP_QUEUE_DEPTH))
        else $error("pending queue occupancy above its depth");

    // No push lands on a full queue.
    push_not_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_i)
        else $error("push while the pending queue is full");

    // A resolve always finds an entry to pop.
    pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        resolve_i |-> not_empty_i)
        else $error("resolve while no prediction is pending");

    // The mispredict pulse follows a resolve by one cycle.
    mispredict_after_resolve: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mispredict_i |-> $past(resolve_i))
        else $error("mispredict without a resolve in the previous cycle");

    // Everything is quiet right after a reset edge.
    reset_values: assert property (@(posedge clk_i)
        !rst_n_i |=> (count_i == '0) && !not_empty_i && !mispredict_i && !predict_valid_i)
        else $error("outputs not at their reset values");

endmodule

bind pending_branch_queue branch_predict_sva u_queue_sva (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .count_i         (count_q),
    .push_i          (push_i),
    .full_i          (full_o),
    .resolve_i       (rsv.resolve),
    .not_empty_i     (rsv.not_empty),
    .mispredict_i    (1'b0),
    .predict_valid_i (1'b0)
);

bind gshare_predictor branch_predict_sva u_gshare_sva (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .count_i         ('0),
    .push_i          (1'b0),
    .full_i          (1'b0),
    .resolve_i       (rsv.resolve),
    .not_empty_i     (rsv.not_empty),
    .mispredict_i    (mispredict_o),
    .predict_valid_i (predict_valid_o)
);

/* design/branch_predict_top.sv */
`timescale 1ns/1ns

`include "bp_settings.svh"

module branch_predict_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Fetch lookup.
    input  logic                 lookup_i,
    input  logic [`BP_PC_W-1:0]  lookup_pc_i,

    // Decode install.
    input  logic                 install_i,
    input  logic [`BP_PC_W-1:0]  install_pc_i,
    input  logic [`BP_PC_W-1:0]  install_target_i,

    // Execute resolve, only while a prediction is pending.
    input  logic                 resolve_i,
    input  logic                 resolve_taken_i,
    input  logic [`BP_PC_W-1:0]  resolve_target_i,

    // Prediction and misprediction.
    output logic                 predict_valid_o,
    output logic                 predict_taken_o,
    output logic [`BP_PC_W-1:0]  predict_target_o,
    output logic                 mispredict_o
);

    btb_pkg::btb_result_t  btb_result;
    logic                  push;
    pred_pkg::pending_t    push_entry;
    logic                  queue_full;

    resolve_if rsv_bus ();

    // The resolve event feeds both the queue pop and the predictor training.
    assign rsv_bus.resolve        = resolve_i;
    assign rsv_bus.resolve_taken  = resolve_taken_i;
    assign rsv_bus.resolve_target = resolve_target_i;

    branch_target_buffer u_btb (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .lookup_i         (lookup_i),
        .lookup_pc_i      (lookup_pc_i),
        .install_i        (install_i),
        .install_pc_i     (install_pc_i),
        .install_target_i (install_target_i),
        .result_o         (btb_result)
    );

    gshare_predictor u_gshare (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .btb_result_i     (btb_result),
        .queue_full_i     (queue_full),
        .push_o           (push),
        .push_entry_o     (push_entry),
        .rsv              (rsv_bus.predictor_mp),
        .predict_valid_o  (predict_valid_o),
        .predict_taken_o  (predict_taken_o),
        .predict_target_o (predict_target_o),
        .mispredict_o     (mispredict_o)
    );

    pending_branch_queue u_queue (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (push),
        .push_entry_i (push_entry),
        .full_o       (queue_full),
        .rsv          (rsv_bus.queue_mp)
    );

endmodule

/* design/pending_branch_queue.sv */
`timescale 1ns/1ns

`include "bp_settings.svh"

module pending_branch_queue (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // Push port from the predictor, one entry per reported prediction.
    input  logic               push_i,
    input  pred_pkg::pending_t push_entry_i,
    output logic               full_o,

    // Head entry out and resolve in.
    resolve_if.queue_mp        rsv
);

    localparam int unsigned DEPTH = `BP_QUEUE_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);

    pred_pkg::pending_t  entries_q [DEPTH];
    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [PTR_W:0]      count_q;
    logic                do_push;
    logic                do_pop;

    assign full_o        = (count_q == (PTR_W+1)'(DEPTH));
    assign rsv.not_empty = (count_q != '0);

    // A push into a full queue and a pop from an empty one are both ignored.
    assign do_push = push_i && !full_o;
    assign do_pop  = rsv.resolve && rsv.not_empty;

    // The head is read straight from storage so the predictor sees it at once.
    assign rsv.head = entries_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            entries_q[wr_ptr_q] <= push_entry_i;
        end
    end

    // The depth is a power of two, so the pointers wrap on their own.
    // A push and a pop in one cycle leave the count unchanged.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* design/gshare_predictor.sv */
`timescale 1ns/1ns

`include "bp_settings.svh"

module gshare_predictor (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Registered BTB answer for the lookup of the previous cycle.
    input  btb_pkg::btb_result_t btb_result_i,

    // Pending queue status and push port.
    input  logic                 queue_full_i,
    output logic                 push_o,
    output pred_pkg::pending_t   push_entry_o,

    // Oldest pending entry and the resolve event.
    resolve_if.predictor_mp      rsv,

    // Prediction towards fetch.
    output logic                 predict_valid_o,
    output logic                 predict_taken_o,
    output logic [`BP_PC_W-1:0]  predict_target_o,

    // One-cycle pulse after a resolve that disagrees with its prediction.
    output logic                 mispredict_o
);

    localparam int unsigned IDX_W  = pred_pkg::IDX_W;
    localparam int unsigned HIST_W = `BP_HIST_LEN;
    localparam int unsigned OFS    = `BP_WORD_OFFSET;

    logic [HIST_W-1:0]   history_q;
    pred_pkg::counter_e  counter_q [`BP_TABLE_DEPTH];

    logic [IDX_W-1:0]    lookup_idx;
    pred_pkg::counter_e  lookup_ctr;
    logic                train_en;
    pred_pkg::counter_e  train_next;
    logic                dir_wrong;
    logic                target_wrong;
    logic                mispredict_q;

    // Moves a counter one step toward the outcome.
    // Both ends hold, so a strong state never wraps into the opposite one.
    function automatic pred_pkg::counter_e step_counter(
        input pred_pkg::counter_e ctr,
        input logic               taken
    );
        pred_pkg::counter_e next;
        next = ctr;
        case (ctr)
            pred_pkg::strongly_not_taken:
                next = taken ? pred_pkg::weakly_not_taken : pred_pkg::strongly_not_taken;
            pred_pkg::weakly_not_taken:
                next = taken ? pred_pkg::weakly_taken : pred_pkg::strongly_not_taken;
            pred_pkg::weakly_taken:
                next = taken ? pred_pkg::strongly_taken : pred_pkg::weakly_not_taken;
            pred_pkg::strongly_taken:
                next = taken ? pred_pkg::strongly_taken : pred_pkg::weakly_taken;
            default:
                next = pred_pkg::weakly_not_taken;
        endcase
        return next;
    endfunction

    // The PC word bits are hashed with the global history.
    // A lookup sees the table and history as they stand in this cycle.
    // A resolve in the same cycle only lands at the clock edge.
    assign lookup_idx = btb_result_i.pc[IDX_W+OFS-1:OFS] ^ IDX_W'(history_q);
    assign lookup_ctr = counter_q[lookup_idx];

    // A hit is only reported when the queue can take it.
    assign predict_valid_o  = btb_result_i.hit && !queue_full_i;
    assign predict_taken_o  = lookup_ctr[1];
    assign predict_target_o = btb_result_i.target;

    // Every reported prediction is remembered until execute resolves it.
    assign push_o = predict_valid_o;

    always_comb begin
        push_entry_o.idx    = lookup_idx;
        push_entry_o.taken  = predict_taken_o;
        push_entry_o.target = btb_result_i.target;
    end

    // Training always acts on the head, since resolves come in program order.
    assign train_en   = rsv.resolve && rsv.not_empty;
    assign train_next = step_counter(counter_q[rsv.head.idx], rsv.resolve_taken);

    // The target only matters when the branch was actually taken.
    assign dir_wrong    = rsv.resolve_taken != rsv.head.taken;
    assign target_wrong = rsv.resolve_taken && (rsv.resolve_target != rsv.head.target);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BP_TABLE_DEPTH; i++) begin
                counter_q[i] <= pred_pkg::weakly_not_taken;
            end
        end else if (train_en) begin
            counter_q[rsv.head.idx] <= train_next;
        end
    end

    // History only moves on resolved outcomes, with the newest in bit 0.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            history_q <= '0;
        end else if (train_en) begin
            history_q <= {history_q[HIST_W-2:0], rsv.resolve_taken};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mispredict_q <= 1'b0;
        end else begin
            mispredict_q <= train_en && (dir_wrong || target_wrong);
        end
    end

    assign mispredict_o = mispredict_q;

endmodule

/* design/branch_target_buffer.sv */
`timescale 1ns/1ns

`include "bp_settings.svh"

module branch_target_buffer (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Lookup port from fetch.
    input  logic                 lookup_i,
    input  logic [`BP_PC_W-1:0]  lookup_pc_i,

    // Install port from decode.
    input  logic                 install_i,
    input  logic [`BP_PC_W-1:0]  install_pc_i,
    input  logic [`BP_PC_W-1:0]  install_target_i,

    // Lookup answer, one cycle after the strobe.
    output btb_pkg::btb_result_t result_o
);

    localparam int unsigned IDX_W = btb_pkg::IDX_W;
    localparam int unsigned TAG_W = btb_pkg::TAG_W;
    localparam int unsigned OFS   = `BP_WORD_OFFSET;

    btb_pkg::btb_entry_t  entries_q [`BP_BTB_ENTRIES];

    logic [IDX_W-1:0]     lookup_idx;
    logic [TAG_W-1:0]     lookup_tag;
    logic [IDX_W-1:0]     install_idx;
    logic [TAG_W-1:0]     install_tag;
    btb_pkg::btb_entry_t  lookup_entry;
    logic                 lookup_hit;

    logic                 hit_q;
    logic [`BP_PC_W-1:0]  target_q;
    logic [`BP_PC_W-1:0]  pc_q;

    // The set index sits just above the word offset and the tag takes the rest.
    assign lookup_idx  = lookup_pc_i[IDX_W+OFS-1:OFS];
    assign lookup_tag  = lookup_pc_i[`BP_PC_W-1:IDX_W+OFS];
    assign install_idx = install_pc_i[IDX_W+OFS-1:OFS];
    assign install_tag = install_pc_i[`BP_PC_W-1:IDX_W+OFS];

    // A lookup hits only on a valid entry whose tag matches.
    assign lookup_entry = entries_q[lookup_idx];
    assign lookup_hit   = lookup_entry.valid && (lookup_entry.tag == lookup_tag);

    // Reset invalidates every entry; tags and targets keep whatever they held.
    // An install overwrites the set, so a newer branch evicts an older alias.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
                entries_q[i].valid <= 1'b0;
            end
        end else if (install_i) begin
            entries_q[install_idx].valid  <= 1'b1;
            entries_q[install_idx].tag    <= install_tag;
            entries_q[install_idx].target <= install_target_i;
        end
    end

    // The hit flag is only high in the cycle after a lookup.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= lookup_i && lookup_hit;
        end
    end

    // Target and PC are captured on every lookup, hit or miss.
    always_ff @(posedge clk_i) begin
        if (lookup_i) begin
            target_q <= lookup_entry.target;
            pc_q     <= lookup_pc_i;
        end
    end

    always_comb begin
        result_o.hit    = hit_q;
        result_o.target = target_q;
        result_o.pc     = pc_q;
    end

endmodule

/* design/resolve_if.sv */
`timescale 1ns/1ns

`include "bp_settings.svh"

interface resolve_if;

    // Oldest in-flight prediction, read combinationally from the queue.
    pred_pkg::pending_t   head;
    // High while at least one prediction waits for its resolve.
    logic                 not_empty;

    // Resolve event from execute for the entry at the head.
    logic                 resolve;
    logic                 resolve_taken;
    logic [`BP_PC_W-1:0]  resolve_target;

    // The queue owns the head and pops it on each resolve.
    modport queue_mp (
        output head,
        output not_empty,
        input  resolve
    );

    // The predictor compares the head with the outcome and trains on it.
    modport predictor_mp (
        input head,
        input not_empty,
        input resolve,
        input resolve_taken,
        input resolve_target
    );

endinterface

/* design/btb_pkg.sv */
`include "bp_settings.svh"

package btb_pkg;

    // Width of a BTB set index.
    localparam int unsigned IDX_W = $clog2(`BP_BTB_ENTRIES);

    // The tag holds every PC bit above the set index and the word offset.
    localparam int unsigned TAG_W = `BP_PC_W - IDX_W - `BP_WORD_OFFSET;

    // One stored branch.
    typedef struct packed {
        logic                 valid;
        logic [TAG_W-1:0]     tag;
        logic [`BP_PC_W-1:0]  target;
    } btb_entry_t;

    // Registered answer to one lookup.
    // The PC travels with it so that gshare can form its hash a cycle later.
    typedef struct packed {
        logic                 hit;
        logic [`BP_PC_W-1:0]  target;
        logic [`BP_PC_W-1:0]  pc;
    } btb_result_t;

endpackage

/* design/pred_pkg.sv */
`include "bp_settings.svh"

package pred_pkg;

    // Width of a counter table index.
    localparam int unsigned IDX_W = $clog2(`BP_TABLE_DEPTH);

    // State of one 2-bit saturating counter.
    // The upper bit alone decides the predicted direction.
    // The table comes out of reset at weakly_not_taken.
    typedef enum logic [1:0] {
        strongly_not_taken = 2'b00,
        weakly_not_taken   = 2'b01,
        weakly_taken       = 2'b10,
        strongly_taken     = 2'b11
    } counter_e;

    // One prediction that waits for its resolve from execute.
    // The index is the hashed one that was used at lookup time.
    // Training must hit the same counter even after the history has moved on.
    typedef struct packed {
        logic [IDX_W-1:0]     idx;
        logic                 taken;
        logic [`BP_PC_W-1:0]  target;
    } pending_t;

endpackage

/* design/bp_settings.svh */
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// Width of a program counter and of every branch target.
`define BP_PC_W 32

// Number of 2-bit counters in the gshare table.
// The counter index width is derived from it.
`define BP_TABLE_DEPTH 64

// Length of the global history register.
// It must not exceed the index width.
`define BP_HIST_LEN 6

// Number of entries in the direct-mapped branch target buffer.
`define BP_BTB_ENTRIES 16

// Number of predictions that may be in flight at once.
// It must be a power of two.
`define BP_QUEUE_DEPTH 4

// Instructions are word aligned, so the two low PC bits carry no information.
`define BP_WORD_OFFSET 2

`endif
